//--- src.f
common/smpc_pkg.sv
src/smpc_host_regs.sv
src/smpc_rtc.sv
cmd/smpc_cmd_seq.sv
src/smpc_oreg.sv
src/smpc_top.sv
tests/smpc_tb_clock.sv
tests/smpc_assertions.sv
tests/smpc_tb.sv

//--- tests/smpc_tb.sv
`timescale 1ns/1ps
`default_nettype none

module smpc_tb import smpc_pkg::*; ();

	logic       CLK, RST_N, CE, MRES_N, TIME_SET, CS_N, RW_N;
	logic [3:0] AC;
	logic [5:0] A;
	logic [7:0] DI, DO;
	logic       MSHRES_N, MSHNMI_N, SSHRES_N, SSHNMI_N, SNDRES_N, CDRES_N, MIRQ_N;

	integer     seed;
	int         cyc = 0;
	int         t0, t1;
	logic [5:0] m_lines;	// mshres, mshnmi, sshres, sshnmi, sndres, cdres
	logic       m_ste, m_resd;
	int         tc [6];	// year, month, days, hour, min, sec
	logic [3:0] cal_wd;
	logic [7:0] status [16];
	logic [7:0] prev [16];
	logic [7:0] echo;
	logic       mirq_seen;

	smpc_tb_clock u_clk (.CLK(CLK), .RST_N(RST_N));

	smpc_top #(.TICKS_PER_SEC(16)) UUT (
		.CLK, .RST_N, .CE, .MRES_N, .TIME_SET, .AC, .A, .DI, .DO, .CS_N, .RW_N,
		.MSHRES_N, .MSHNMI_N, .SSHRES_N, .SSHNMI_N, .SNDRES_N, .CDRES_N, .MIRQ_N
	);

	always @(posedge CLK)
		cyc <= cyc + 1;

	always @(negedge CLK)
		if (!MIRQ_N)
			mirq_seen = 1'b1;

	always @(negedge CLK)
		if (UUT.u_seq.u_sva.fail_cnt != 0)
			fail_now("A sequencer assertion failed");

	task automatic fail_now(input string what);
		$display("%s at %0t", what, $time);
		$display("SOME TESTS FAILED");
		$fatal(1);
	endtask

	task automatic check(input string name, input logic [63:0] exp, input logic [63:0] act);
		if (exp !== act) begin
			$display("[FAIL] t=%0t %s expected %0h actual %0h", $time, name, exp, act);
			$display("SOME TESTS FAILED");
			$fatal(1);
		end
	endtask

	task automatic bus_write(input logic [5:0] adr, input logic [7:0] d);
		@(negedge CLK);
		A = adr;
		DI = d;
		CS_N = 1'b0;
		RW_N = 1'b0;
		@(negedge CLK);
		CS_N = 1'b1;
		RW_N = 1'b1;
	endtask

	task automatic bus_read(input logic [5:0] adr, output logic [7:0] d);
		@(negedge CLK);
		A = adr;
		CS_N = 1'b0;
		RW_N = 1'b1;
		@(negedge CLK);
		d = DO;
		CS_N = 1'b1;
	endtask

	task automatic wait_sf();
		logic [7:0] v;
		int n;
		for (n = 0; n < 5000; n++) begin
			bus_read(6'h31, v);
			if (!v[0])
				break;
		end
		if (n == 5000)
			fail_now("SF never cleared after a command");
	endtask

	task automatic run_cmd(input logic [7:0] op);
		bus_write(6'h0F, op);
		bus_write(6'h31, 8'h01);
		wait_sf();
	endtask

	function automatic logic [5:0] pins();
		return {MSHRES_N, MSHNMI_N, SSHRES_N, SSHNMI_N, SNDRES_N, CDRES_N};
	endfunction

	function automatic logic [7:0] bcd(input int v);
		return 8'((v / 10) * 16 + v % 10);
	endfunction

	function automatic int mlen(input int mo);
		if (mo == 2)
			return 28;
		else if (mo == 4 || mo == 6 || mo == 9 || mo == 11)
			return 30;
		return 31;
	endfunction

	task automatic advance_tc();
		tc[5]++;
		if (tc[5] == 60) begin
			tc[5] = 0;
			tc[4]++;
		end
		if (tc[4] == 60) begin
			tc[4] = 0;
			tc[3]++;
		end
		if (tc[3] == 24) begin
			tc[3] = 0;
			tc[2]++;
		end
		if (tc[2] > mlen(tc[1])) begin
			tc[2] = 1;
			tc[1]++;
		end
		if (tc[1] == 13) begin
			tc[1] = 1;
			tc[0] = (tc[0] + 1) % 10000;
		end
	endtask

	function automatic logic [55:0] tc_bytes();
		return {bcd(tc[0] / 100), bcd(tc[0] % 100), cal_wd, 4'(tc[1]), bcd(tc[2]),
			bcd(tc[3]), bcd(tc[4]), bcd(tc[5])};
	endfunction

	task automatic intback_read();
		bus_write(6'h00, 8'h01);
		bus_write(6'h02, 8'hF0);
		mirq_seen = 1'b0;
		run_cmd(OP_INTBACK);
		t1 = cyc;
		check("mirq_low", 1'b1, mirq_seen);
		for (int i = 0; i < 16; i++)
			bus_read(6'h10 + 6'(i), status[i]);
		bus_read(6'h2F, echo);
	endtask

	task automatic check_status();
		logic [7:0] v;
		check("oreg0", {m_ste, m_resd, 6'd0}, status[0]);
		check("oreg8", 8'h00, status[8]);
		check("oreg9", {4'd0, AC}, status[9]);
		check("oreg10", {4'b0011, ~m_lines[4], 2'b10, ~m_lines[1]}, status[10]);
		check("oreg11", {1'b0, ~m_lines[0], 6'd0}, status[11]);
		for (int i = 12; i < 16; i++)
			check("oreg_smem", 8'h00, status[i]);
		check("oreg31", OP_INTBACK, echo);
		bus_read(6'h30, v);
		check("sr", 8'h4F, v);
		check("lines", m_lines, pins());
	endtask

	task automatic settime_check(input int y, mo, d, h, mi, s);
		int el, lo, hi;
		logic [55:0] exp_b [8];
		logic [55:0] got, mask;
		logic ok;
		cal_wd = 4'($unsigned($random(seed)) % 7);
		bus_write(6'h00, bcd(y / 100));
		bus_write(6'h01, bcd(y % 100));
		bus_write(6'h02, {cal_wd, 4'(mo)});
		bus_write(6'h03, bcd(d));
		bus_write(6'h04, bcd(h));
		bus_write(6'h05, bcd(mi));
		bus_write(6'h06, bcd(s));
		run_cmd(OP_SETTIME);
		t0 = cyc;
		m_ste = 1'b1;
		intback_read();
		check_status();
		// Status bytes are captured about 24 cycles before SF falls
		el = t1 - t0 - 24;
		lo = (el / 16 > 0) ? el / 16 - 1 : 0;
		hi = el / 16 + 1;
		tc = '{y, mo, d, h, mi, s};
		for (int k = 0; k < lo; k++)
			advance_tc();
		for (int k = 0; k <= hi - lo + 1; k++) begin
			exp_b[k] = tc_bytes();
			advance_tc();
		end
		got = {status[1], status[2], status[3], status[4], status[5], status[6], status[7]};
		ok = 1'b0;
		// A tick may land between byte writes, splitting old and new time
		for (int k = 0; k <= hi - lo; k++) begin
			for (int j = 0; j < 8; j++) begin
				mask = ~({56{1'b1}} >> (8 * j));
				if (got == ((exp_b[k] & mask) | (exp_b[k + 1] & ~mask)))
					ok = 1'b1;
			end
		end
		if (!ok)
			check("rtc_time", exp_b[1], got);
	endtask

	function automatic logic is_known(input logic [7:0] op);
		case (op)
			8'h00, 8'h02, 8'h03, 8'h06, 8'h07, 8'h08, 8'h09, 8'h10, 8'h16, 8'h18,
			8'h19, 8'h1A: return 1'b1;
			default: return 1'b0;
		endcase
	endfunction

	initial begin
		logic [7:0] op, v;
		logic [7:0] pwr_ops [7];
		int n, mo;
		CE = 1'b1;
		MRES_N = 1'b1;
		TIME_SET = 1'b0;
		AC = 4'd0;
		A = 6'd0;
		DI = 8'h00;
		CS_N = 1'b1;
		RW_N = 1'b1;
		mirq_seen = 1'b0;
		seed = 32'h5efd71b5;
		pwr_ops = '{OP_MSHON, OP_SSHON, OP_SSHOFF, OP_SNDON, OP_SNDOFF, OP_CDON, OP_CDOFF};
		AC = 4'($random(seed));
		for (n = 0; n < 100 && !RST_N; n++)
			@(negedge CLK);
		if (!RST_N)
			fail_now("Reset never released");

		// Reset defaults and MRES_N pulse
		@(negedge CLK);
		check("lines_rst", 6'b000000, pins());
		check("mirq_n", 1'b1, MIRQ_N);
		MRES_N = 1'b0;
		TIME_SET = 1'($random(seed));
		repeat (4) @(negedge CLK);
		check("lines_mres", 6'b110101, pins());
		MRES_N = 1'b1;
		m_lines = 6'b110101;
		m_ste = TIME_SET;
		m_resd = 1'b1;
		intback_read();
		check_status();

		// Random power commands
		for (int i = 0; i < 12; i++) begin
			op = pwr_ops[$unsigned($random(seed)) % 7];
			case (op)
				OP_MSHON:  m_lines[5:4] = 2'b11;
				OP_SSHON:  m_lines[3:2] = 2'b11;
				OP_SSHOFF: m_lines[3:2] = 2'b01;
				OP_SNDON:  m_lines[1] = 1'b1;
				OP_SNDOFF: m_lines[1] = 1'b0;
				OP_CDON:   m_lines[0] = 1'b1;
				default:   m_lines[0] = 1'b0;
			endcase
			run_cmd(op);
			check("lines", m_lines, pins());
			check("mirq_n", 1'b1, MIRQ_N);
			bus_read(6'h2F, v);
			check("oreg31", op, v);
		end

		// NMIREQ pulses the master NMI
		bus_write(6'h0F, OP_NMIREQ);
		bus_write(6'h31, 8'h01);
		for (n = 0; n < 2000 && MSHNMI_N; n++)
			@(negedge CLK);
		if (MSHNMI_N)
			fail_now("MSHNMI_N never went low on NMIREQ");
		wait_sf();
		m_lines[4] = 1'b1;
		check("lines_nmi", m_lines, pins());

		// Unknown opcodes only echo
		for (int i = 0; i < 6; i++) begin
			op = 8'($random(seed));
			while (is_known(op))
				op = op + 8'h23;
			run_cmd(op);
			check("lines_unk", m_lines, pins());
			bus_read(6'h2F, v);
			check("oreg31_unk", op, v);
		end

		// RESD through INTBACK byte 0
		run_cmd(OP_RESENAB);
		m_resd = 1'b0;
		intback_read();
		check_status();
		run_cmd(OP_RESDISA);
		m_resd = 1'b1;
		intback_read();
		check_status();

		// SETTIME with carries, then random dates
		settime_check(1999, 12, 31, 23, 59, 30);
		settime_check(2023, 2, 28, 23, 59, 20);
		settime_check(2024, 4, 30, 23, 59, 40);
		for (int i = 0; i < 3; i++) begin
			mo = $unsigned($random(seed)) % 12 + 1;
			settime_check($unsigned($random(seed)) % 10000, mo,
				$unsigned($random(seed)) % mlen(mo) + 1, $unsigned($random(seed)) % 24,
				$unsigned($random(seed)) % 60, $unsigned($random(seed)) % 60);
		end

		// INTBACK without F0 in IREG2 leaves status untouched
		prev = status;
		run_cmd(OP_RESDISA);
		v = 8'($random(seed));
		if (v == 8'hF0)
			v = 8'h0F;
		bus_write(6'h02, v);
		run_cmd(OP_INTBACK);
		for (int i = 0; i < 16; i++) begin
			bus_read(6'h10 + 6'(i), status[i]);
			check("oreg_kept", prev[i], status[i]);
		end
		bus_read(6'h2F, v);
		check("oreg31_skip", OP_INTBACK, v);
		check("mirq_n", 1'b1, MIRQ_N);

		if (UUT.u_seq.u_sva.fail_cnt != 0)
			fail_now("A sequencer assertion failed");
		else begin
			$display("ALL TESTS PASSED");
			$finish;
		end
	end

endmodule

`default_nettype wire

//--- tests/smpc_assertions.sv
`timescale 1ns/1ps
`default_nettype none

module smpc_assertions import smpc_pkg::*; (
	input logic       CLK,
	input logic       RST_N,
	input cmd_state_e state,
	input logic       cmd_valid,
	input logic       cmd_ready,
	input logic       sf_clear,
	input logic       time_load,
	input logic       mirq_n
);

	int fail_cnt = 0;

	a_ready_accept: assert property (@(posedge CLK) disable iff (!RST_N)
		cmd_valid && cmd_ready |=> state == CS_WAIT)
		else begin
			fail_cnt++;
			$error("accepted command did not enter CS_WAIT");
		end

	a_sf_clear_pulse: assert property (@(posedge CLK) disable iff (!RST_N)
		sf_clear |=> !sf_clear)
		else begin
			fail_cnt++;
			$error("sf_clear longer than one cycle");
		end

	a_time_load_pulse: assert property (@(posedge CLK) disable iff (!RST_N)
		time_load |=> !time_load)
		else begin
			fail_cnt++;
			$error("time_load longer than one cycle");
		end

	a_mirq_end: assert property (@(posedge CLK) disable iff (!RST_N)
		!mirq_n |-> state == CS_END)
		else begin
			fail_cnt++;
			$error("mirq_n low outside CS_END");
		end

endmodule

bind smpc_cmd_seq smpc_assertions u_sva (
	.CLK(CLK), .RST_N(RST_N), .state(state), .cmd_valid(cmd_valid),
	.cmd_ready(cmd_ready), .sf_clear(sf_clear), .time_load(time_load), .mirq_n(mirq_n)
);

`default_nettype wire

//--- tests/smpc_tb_clock.sv
`timescale 1ns/1ps
`default_nettype none

module smpc_tb_clock (
	output logic CLK,
	output logic RST_N
);

	initial begin
		CLK = 1'b0;
		forever #10 CLK = ~CLK;	// 20 ns period
	end

	initial begin
		RST_N = 1'b0;
		repeat (10) @(negedge CLK);
		RST_N = 1'b1;
	end

endmodule

`default_nettype wire

//--- src/smpc_top.sv
`timescale 1ns/1ps
`default_nettype none

module smpc_top import smpc_pkg::*; #(
	parameter int TICKS_PER_SEC = 4000000
) (
	input  logic       CLK,
	input  logic       RST_N,
	input  logic       CE,
	input  logic       MRES_N,
	input  logic       TIME_SET,
	input  logic [3:0] AC,
	input  logic [5:0] A,
	input  logic [7:0] DI,
	output logic [7:0] DO,
	input  logic       CS_N,
	input  logic       RW_N,
	output logic       MSHRES_N,
	output logic       MSHNMI_N,
	output logic       SSHRES_N,
	output logic       SSHNMI_N,
	output logic       SNDRES_N,
	output logic       CDRES_N,
	output logic       MIRQ_N
);

	ireg_t        ireg;
	logic         cmd_valid;
	logic         cmd_ready;
	logic [7:0]   comreg;
	logic         sf_clear;
	logic [7:0]   sr;
	logic [4:0]   oreg_raddr;
	logic [7:0]   oreg_rdata;
	logic         time_load;
	bcd_time_t    now;
	reset_lines_t resets;
	sys_flags_t   flags;
	oreg_req_t    oreg_req;

	smpc_host_regs u_host (
		.CLK, .RST_N, .A, .DI, .CS_N, .RW_N, .DO,
		.ireg, .cmd_valid, .cmd_ready, .comreg, .sf_clear, .sr,
		.oreg_raddr, .oreg_rdata
	);

	smpc_rtc #(.TICKS_PER_SEC(TICKS_PER_SEC)) u_rtc (
		.CLK, .RST_N, .CE, .ireg, .time_load, .now
	);

	smpc_cmd_seq u_seq (
		.CLK, .RST_N, .CE, .MRES_N, .TIME_SET,
		.cmd_valid, .cmd_ready, .comreg, .ireg,
		.resets, .mirq_n(MIRQ_N), .flags, .sr, .sf_clear, .time_load, .oreg_req
	);

	smpc_oreg u_oreg (
		.CLK, .RST_N, .oreg_req, .now, .flags, .resets, .AC,
		.raddr(oreg_raddr), .rdata(oreg_rdata)
	);

	assign MSHRES_N = resets.mshres_n;
	assign MSHNMI_N = resets.mshnmi_n;
	assign SSHRES_N = resets.sshres_n;
	assign SSHNMI_N = resets.sshnmi_n;
	assign SNDRES_N = resets.sndres_n;
	assign CDRES_N  = resets.cdres_n;

endmodule

`default_nettype wire

//--- src/smpc_oreg.sv
`timescale 1ns/1ps
`default_nettype none

module smpc_oreg import smpc_pkg::*; (
	input  logic         CLK,
	input  logic         RST_N,
	input  oreg_req_t    oreg_req,
	input  bcd_time_t    now,
	input  sys_flags_t   flags,
	input  reset_lines_t resets,
	input  logic [3:0]   AC,
	input  logic [4:0]   raddr,
	output logic [7:0]   rdata
);

	logic [7:0] oreg [32];
	logic [7:0] wdata;

	always_comb begin
		wdata = 8'h00;
		if (oreg_req.index == OREG_LAST)
			wdata = oreg_req.comreg;
		else if (oreg_req.index < OREG_STATUS_LEN) begin
			case (oreg_req.index)
				5'd0:  wdata = {flags.ste, flags.resd, 6'd0};
				5'd1:  wdata = now.year[15:8];
				5'd2:  wdata = now.year[7:0];
				5'd3:  wdata = {now.day, now.month};
				5'd4:  wdata = now.days;
				5'd5:  wdata = now.hour;
				5'd6:  wdata = now.min;
				5'd7:  wdata = now.sec;
				5'd9:  wdata = {4'd0, AC};
				5'd10: wdata = {4'b0011, ~resets.mshnmi_n, 2'b10, ~resets.sndres_n};
				5'd11: wdata = {1'b0, ~resets.cdres_n, 6'd0};
				default: wdata = 8'h00;	// SMEM bytes read 0
			endcase
		end
	end

	always_ff @(posedge CLK or negedge RST_N) begin
		if (!RST_N) begin
			for (int i = 0; i < 32; i++)
				oreg[i] <= 8'h00;
		end else if (oreg_req.valid)
			oreg[oreg_req.index] <= wdata;
	end

	assign rdata = oreg[raddr];

endmodule

`default_nettype wire

//--- cmd/smpc_cmd_seq.sv
`timescale 1ns/1ps
`default_nettype none

module smpc_cmd_seq import smpc_pkg::*; (
	input  logic         CLK,
	input  logic         RST_N,
	input  logic         CE,
	input  logic         MRES_N,
	input  logic         TIME_SET,
	input  logic         cmd_valid,
	output logic         cmd_ready,
	input  logic [7:0]   comreg,
	input  ireg_t        ireg,
	output reset_lines_t resets,
	output logic         mirq_n,
	output sys_flags_t   flags,
	output logic [7:0]   sr,
	output logic         sf_clear,
	output logic         time_load,
	output oreg_req_t    oreg_req
);

	cmd_state_e  state;
	logic [15:0] wait_cnt;
	logic        decoded;	// Accept delay done
	logic [7:0]  cmd_q;
	logic [4:0]  oreg_cnt;
	logic        intb_ok;
	logic        decode_now;
	logic        decode_skip;

	function automatic logic [15:0] cmd_delay(input logic [7:0] op);
		case (op)
			OP_MSHON, OP_SSHON, OP_SSHOFF,
			OP_SNDON, OP_SNDOFF:             return DLY_POWER;
			OP_CDON, OP_CDOFF:               return DLY_CD;
			OP_INTBACK:                      return DLY_INTBACK;
			OP_SETTIME:                      return DLY_SETTIME;
			OP_NMIREQ, OP_RESENAB, OP_RESDISA: return DLY_NMI;
			default:                         return 16'd1;
		endcase
	endfunction

	assign intb_ok = (ireg[2] == 8'hF0) && ireg[0][0];
	assign decode_now = (state == CS_WAIT) && (wait_cnt == 16'd0) && !decoded;
	assign decode_skip = decode_now && (cmd_q == OP_INTBACK) && !intb_ok;

	assign cmd_ready = CE && MRES_N && (state == CS_IDLE);
	assign sf_clear = CE && (state == CS_END);
	assign time_load = CE && (state == CS_EXEC) && (cmd_q == OP_SETTIME);

	// Echo at OREG_LAST, INTBACK status walks all indexes
	assign oreg_req.valid = CE && MRES_N && ((state == CS_EXEC) || decode_skip);
	assign oreg_req.index = (state == CS_EXEC && cmd_q == OP_INTBACK) ? oreg_cnt : OREG_LAST;
	assign oreg_req.comreg = cmd_q;

	always_ff @(posedge CLK or negedge RST_N) begin
		if (!RST_N) begin
			state <= CS_IDLE;
			wait_cnt <= 16'd0;
			decoded <= 1'b0;
			cmd_q <= 8'h00;
			oreg_cnt <= 5'd0;
			resets <= '0;
			mirq_n <= 1'b1;
			flags <= '{ste: 1'b0, resd: 1'b1};
			sr <= 8'h00;
		end else if (!MRES_N) begin
			resets <= '{mshres_n: 1'b1, mshnmi_n: 1'b1, sshres_n: 1'b0,
				sshnmi_n: 1'b1, sndres_n: 1'b0, cdres_n: 1'b1};
			mirq_n <= 1'b1;
			flags <= '{ste: TIME_SET, resd: 1'b1};
			sr <= 8'h00;
			state <= CS_IDLE;
		end else if (CE) begin
			case (state)
				CS_IDLE: begin
					if (cmd_valid && cmd_ready) begin
						cmd_q <= comreg;
						wait_cnt <= DLY_ACCEPT - 16'd1;
						decoded <= 1'b0;
						oreg_cnt <= 5'd0;
						state <= CS_WAIT;
					end
				end
				CS_WAIT: begin
					if (wait_cnt != 16'd0)
						wait_cnt <= wait_cnt - 16'd1;
					else if (decode_now) begin
						decoded <= 1'b1;
						if (decode_skip)
							state <= CS_END;	// Echo only
						else
							wait_cnt <= cmd_delay(cmd_q) - 16'd1;
					end else
						state <= CS_EXEC;
				end
				CS_EXEC: begin
					state <= CS_END;
					case (cmd_q)
						OP_MSHON: begin
							resets.mshres_n <= 1'b1;
							resets.mshnmi_n <= 1'b1;
						end
						OP_SSHON: begin
							resets.sshres_n <= 1'b1;
							resets.sshnmi_n <= 1'b1;
						end
						OP_SSHOFF: begin
							resets.sshres_n <= 1'b0;
							resets.sshnmi_n <= 1'b1;
						end
						OP_SNDON:   resets.sndres_n <= 1'b1;
						OP_SNDOFF:  resets.sndres_n <= 1'b0;
						OP_CDON:    resets.cdres_n <= 1'b1;
						OP_CDOFF:   resets.cdres_n <= 1'b0;
						OP_SETTIME: flags.ste <= 1'b1;
						OP_NMIREQ:  resets.mshnmi_n <= 1'b0;	// Released in END
						OP_RESENAB: flags.resd <= 1'b0;
						OP_RESDISA: flags.resd <= 1'b1;
						OP_INTBACK: begin
							oreg_cnt <= oreg_cnt + 5'd1;
							if (oreg_cnt == OREG_LAST) begin
								sr <= 8'b0100_1111;
								mirq_n <= 1'b0;
							end else
								state <= CS_EXEC;
						end
						default: ;
					endcase
				end
				CS_END: begin
					if (cmd_q == OP_NMIREQ)
						resets.mshnmi_n <= 1'b1;
					mirq_n <= 1'b1;
					state <= CS_IDLE;
				end
				default: state <= CS_IDLE;
			endcase
		end
	end

endmodule

`default_nettype wire

//--- src/smpc_rtc.sv
`timescale 1ns/1ps
`default_nettype none

module smpc_rtc import smpc_pkg::*; #(
	parameter int TICKS_PER_SEC = 4000000
) (
	input  logic      CLK,
	input  logic      RST_N,
	input  logic      CE,
	input  ireg_t     ireg,
	input  logic      time_load,
	output bcd_time_t now
);

	logic [31:0] div_cnt;
	logic        tick;
	bcd_time_t   nxt;
	logic        c_sec, c_min, c_hour, c_days, c_mon, c_ylo;

	// Returns {wrap, next} for a two-digit BCD field
	function automatic logic [8:0] bcd_inc8(input logic [7:0] v, input logic [7:0] last,
			input logic [7:0] first);
		if (v == last)
			return {1'b1, first};
		else if (v[3:0] == 4'd9)
			return {1'b0, v[7:4] + 4'd1, 4'd0};
		else
			return {1'b0, v + 8'd1};
	endfunction

	function automatic logic [7:0] days_last(input logic [3:0] month);
		case (month)
			4'd2:                     return 8'h28;
			4'd4, 4'd6, 4'd9, 4'd11:  return 8'h30;
			default:                  return 8'h31;
		endcase
	endfunction

	assign tick = (div_cnt == TICKS_PER_SEC - 1);

	always_comb begin
		nxt = now;
		c_min = 1'b0;
		c_hour = 1'b0;
		c_days = 1'b0;
		c_mon = 1'b0;
		c_ylo = 1'b0;
		{c_sec, nxt.sec} = bcd_inc8(now.sec, 8'h59, 8'h00);
		if (c_sec)
			{c_min, nxt.min} = bcd_inc8(now.min, 8'h59, 8'h00);
		if (c_min)
			{c_hour, nxt.hour} = bcd_inc8(now.hour, 8'h23, 8'h00);
		if (c_hour)
			{c_days, nxt.days} = bcd_inc8(now.days, days_last(now.month), 8'h01);
		if (c_days) begin
			c_mon = (now.month == 4'd12);
			nxt.month = c_mon ? 4'd1 : now.month + 4'd1;
		end
		if (c_mon)
			{c_ylo, nxt.year[7:0]} = bcd_inc8(now.year[7:0], 8'h99, 8'h00);
		if (c_ylo)
			nxt.year[15:8] = 8'(bcd_inc8(now.year[15:8], 8'h99, 8'h00));
	end

	always_ff @(posedge CLK or negedge RST_N) begin
		if (!RST_N) begin
			div_cnt <= '0;
			now <= '{sec: 8'h00, min: 8'h00, hour: 8'h00, days: 8'h01,
				day: 4'd0, month: 4'd1, year: 16'h2024};
		end else if (time_load) begin
			div_cnt <= '0;	// Restart the second on load
			now <= '{sec: ireg[6], min: ireg[5], hour: ireg[4], days: ireg[3],
				day: ireg[2][7:4], month: ireg[2][3:0], year: {ireg[0], ireg[1]}};
		end else if (CE) begin
			div_cnt <= tick ? '0 : div_cnt + 32'd1;
			if (tick)
				now <= nxt;
		end
	end

endmodule

`default_nettype wire

//--- src/smpc_host_regs.sv
`timescale 1ns/1ps
`default_nettype none

module smpc_host_regs import smpc_pkg::*; (
	input  logic       CLK,
	input  logic       RST_N,
	input  logic [5:0] A,
	input  logic [7:0] DI,
	input  logic       CS_N,
	input  logic       RW_N,
	output logic [7:0] DO,
	output ireg_t      ireg,
	output logic       cmd_valid,
	input  logic       cmd_ready,
	output logic [7:0] comreg,
	input  logic       sf_clear,
	input  logic [7:0] sr,
	output logic [4:0] oreg_raddr,
	input  logic [7:0] oreg_rdata
);

	logic [6:0] addr;
	logic       rw_n_q;
	logic       cs_n_q;
	logic       sf;
	logic       wr_stb;
	logic       rd_stb;
	logic [7:0] rd_mux;

	assign addr = {A, 1'b1};
	assign wr_stb = !RW_N && rw_n_q && !CS_N;	// Falling RW_N inside CS_N
	assign rd_stb = !CS_N && cs_n_q && RW_N;
	assign oreg_raddr = A[4:0] - 5'h10;

	always_comb begin
		if (addr >= ADR_OREG_LO && addr <= ADR_OREG_HI)
			rd_mux = oreg_rdata;
		else if (addr == ADR_SR)
			rd_mux = sr;
		else if (addr == ADR_SF)
			rd_mux = {7'd0, sf};
		else
			rd_mux = 8'h00;
	end

	always_ff @(posedge CLK or negedge RST_N) begin
		if (!RST_N) begin
			rw_n_q <= 1'b1;
			cs_n_q <= 1'b1;
			ireg <= '0;
			comreg <= 8'h00;
			cmd_valid <= 1'b0;
			sf <= 1'b0;
			DO <= 8'h00;
		end else begin
			rw_n_q <= RW_N;
			cs_n_q <= CS_N;

			if (cmd_valid && cmd_ready)
				cmd_valid <= 1'b0;
			if (sf_clear)
				sf <= 1'b0;

			if (wr_stb) begin
				if (addr >= ADR_IREG0 && addr <= ADR_IREG6)
					ireg[A[2:0]] <= DI;
				else if (addr == ADR_COMREG) begin
					comreg <= DI;
					cmd_valid <= 1'b1;	// Pending until taken
				end else if (addr == ADR_SF && DI[0])
					sf <= 1'b1;
			end

			if (rd_stb)
				DO <= rd_mux;
		end
	end

endmodule

`default_nettype wire

//--- common/smpc_pkg.sv
`default_nettype none

package smpc_pkg;

	typedef enum logic [7:0] {
		OP_MSHON    = 8'h00,
		OP_SSHON    = 8'h02,
		OP_SSHOFF   = 8'h03,
		OP_SNDON    = 8'h06,
		OP_SNDOFF   = 8'h07,
		OP_CDON     = 8'h08,
		OP_CDOFF    = 8'h09,
		OP_INTBACK  = 8'h10,
		OP_SETTIME  = 8'h16,
		OP_NMIREQ   = 8'h18,
		OP_RESENAB  = 8'h19,
		OP_RESDISA  = 8'h1A
	} smpc_op_e;

	typedef enum logic [2:0] {
		CS_IDLE,
		CS_WAIT,
		CS_EXEC,
		CS_END
	} cmd_state_e;

	// Command delays in CE cycles
	localparam logic [15:0] DLY_POWER   = 16'd120;
	localparam logic [15:0] DLY_CD      = 16'd159;
	localparam logic [15:0] DLY_INTBACK = 16'd800;
	localparam logic [15:0] DLY_SETTIME = 16'd279;
	localparam logic [15:0] DLY_NMI     = 16'd127;
	localparam logic [15:0] DLY_ACCEPT  = 16'd90;

	localparam logic [4:0] OREG_LAST       = 5'd31;	// Command echo slot
	localparam logic [4:0] OREG_STATUS_LEN = 5'd16;

	// Byte addresses on the host bus
	localparam logic [6:0] ADR_IREG0   = 7'h01;
	localparam logic [6:0] ADR_IREG6   = 7'h0D;
	localparam logic [6:0] ADR_COMREG  = 7'h1F;
	localparam logic [6:0] ADR_OREG_LO = 7'h21;
	localparam logic [6:0] ADR_OREG_HI = 7'h5F;
	localparam logic [6:0] ADR_SR      = 7'h61;
	localparam logic [6:0] ADR_SF      = 7'h63;

	typedef struct packed {
		logic [7:0]  sec;
		logic [7:0]  min;
		logic [7:0]  hour;
		logic [7:0]  days;
		logic [3:0]  day;	// Weekday
		logic [3:0]  month;	// Binary 1 to 12
		logic [15:0] year;
	} bcd_time_t;

	typedef logic [6:0][7:0] ireg_t;

	typedef struct packed {
		logic mshres_n;
		logic mshnmi_n;
		logic sshres_n;
		logic sshnmi_n;
		logic sndres_n;
		logic cdres_n;
	} reset_lines_t;

	typedef struct packed {
		logic       valid;
		logic [4:0] index;
		logic [7:0] comreg;
	} oreg_req_t;

	typedef struct packed {
		logic ste;
		logic resd;
	} sys_flags_t;

endpackage

`default_nettype wire
